//--- include/bridge_settings.svh
// bridge widths, beat offset, return FIFO depth and response entry width
`ifndef BRIDGE_SETTINGS_SVH
`define BRIDGE_SETTINGS_SVH

// physical byte address
`define BRIDGE_PADDR_WIDTH 32

// one Wishbone data word
`define BRIDGE_DATA_WIDTH 64

// largest command, 16 beats of 64 bits
`define BRIDGE_BLOCK_WIDTH 1024

// byte offset bits within a bus word
`define BRIDGE_BUS_OFFSET_WIDTH 3

// return FIFO depth must stay a power of two
`define BRIDGE_REV_FIFO_ELS 4
`define BRIDGE_REV_FIFO_PTR_WIDTH 2

// type, address, size, data and last of one response
`define BRIDGE_REV_ENTRY_WIDTH (1 + `BRIDGE_PADDR_WIDTH + 3 + `BRIDGE_DATA_WIDTH + 1)
`endif

//--- rtl/mem_msg_pkg.sv
// memory-message types: message type, size, address, data, beat count, response entry
`default_nettype none

`include "bridge_settings.svh"

package mem_msg_pkg;

  typedef logic [`BRIDGE_PADDR_WIDTH-1:0] paddr_t;
  typedef logic [`BRIDGE_DATA_WIDTH-1:0] data_t;

  // beat index inside the largest command
  typedef logic [$clog2(`BRIDGE_BLOCK_WIDTH / `BRIDGE_DATA_WIDTH)-1:0] beat_cnt_t;

  // packed response as it sits in the return FIFO
  typedef logic [`BRIDGE_REV_ENTRY_WIDTH-1:0] rev_entry_t;

  typedef enum logic [0:0] {
    e_mem_uc_rd = 1'b0,
    e_mem_uc_wr = 1'b1
  } msg_type_e;

  // log2 of the byte count
  typedef enum logic [2:0] {
    e_size_1   = 3'd0,
    e_size_2   = 3'd1,
    e_size_4   = 3'd2,
    e_size_8   = 3'd3,
    e_size_16  = 3'd4,
    e_size_32  = 3'd5,
    e_size_64  = 3'd6,
    e_size_128 = 3'd7
  } msg_size_e;

  // index of the final bus beat, also the wrap mask of a burst
  function automatic beat_cnt_t size_last_beat(msg_size_e size);
    case (size)
      e_size_16:  return beat_cnt_t'(1);
      e_size_32:  return beat_cnt_t'(3);
      e_size_64:  return beat_cnt_t'(7);
      e_size_128: return beat_cnt_t'(15);
      default:    return beat_cnt_t'(0);
    endcase
  endfunction

endpackage

`default_nettype wire

//--- rtl/wb_pkg.sv
// Wishbone types: word address, byte select, cycle type and burst type
`default_nettype none

`include "bridge_settings.svh"

package wb_pkg;

  typedef logic [`BRIDGE_PADDR_WIDTH-`BRIDGE_BUS_OFFSET_WIDTH-1:0] wb_adr_t;
  typedef logic [`BRIDGE_DATA_WIDTH/8-1:0] wb_sel_t;

  typedef enum logic [2:0] {
    e_cti_classic = 3'b000,
    e_cti_incr    = 3'b010,
    e_cti_eob     = 3'b111
  } wb_cti_e;

  // linear only appears on classic cycles
  typedef enum logic [1:0] {
    e_bte_linear = 2'b00,
    e_bte_wrap4  = 2'b01,
    e_bte_wrap8  = 2'b10,
    e_bte_wrap16 = 2'b11
  } wb_bte_e;

endpackage

`default_nettype wire

//--- rtl/fwd_stream_pump.sv
// command pump: header hold FSM, wrapped beat address, write data register
`default_nettype none

`include "bridge_settings.svh"

module fwd_stream_pump
  import mem_msg_pkg::*;
(
  input  wire             clk_i,
  input  wire             rst_n_i,

  input  wire msg_type_e  mem_fwd_msg_type_i,
  input  wire paddr_t     mem_fwd_addr_i,
  input  wire msg_size_e  mem_fwd_size_i,
  input  wire data_t      mem_fwd_data_i,
  input  wire             mem_fwd_last_i,
  input  wire             mem_fwd_v_i,
  output logic            mem_fwd_ready_and_o,

  output msg_type_e       fsm_msg_type_o,
  output paddr_t          fsm_addr_o,
  output msg_size_e       fsm_size_o,
  output data_t           fsm_data_o,
  output logic            fsm_last_o,
  output logic            fsm_v_o,
  input  wire             fsm_yumi_i
);

  typedef enum logic [0:0] {e_idle, e_busy} state_e;

  state_e    state_r;
  logic      ready_en_r;
  logic      data_v_r;
  beat_cnt_t cnt_r;

  msg_type_e type_r;
  paddr_t    addr_r;
  msg_size_e size_r;
  data_t     data_r;
  logic      last_r;

  logic      accept;
  logic      is_write;
  beat_cnt_t last_beat;
  beat_cnt_t word_idx;
  beat_cnt_t wrap_idx;

  assign accept    = mem_fwd_v_i & mem_fwd_ready_and_o;
  assign is_write  = (type_r == e_mem_uc_wr);
  assign last_beat = size_last_beat(size_r);
  assign word_idx  = addr_r[`BRIDGE_BUS_OFFSET_WIDTH +: $bits(beat_cnt_t)];

  // upper index bits stay, lower ones wrap inside the burst
  assign wrap_idx = (word_idx & ~last_beat) | ((word_idx + cnt_r) & last_beat);

  // one cycle of not-ready after reset
  always_comb begin
    unique case (state_r)
      e_idle:  mem_fwd_ready_and_o = ready_en_r;
      default: mem_fwd_ready_and_o = is_write & ~data_v_r;
    endcase
  end

  always_comb begin
    fsm_addr_o = addr_r;
    fsm_addr_o[`BRIDGE_BUS_OFFSET_WIDTH +: $bits(beat_cnt_t)] = wrap_idx;
  end

  assign fsm_msg_type_o = type_r;
  assign fsm_size_o     = size_r;
  assign fsm_data_o     = data_r;
  assign fsm_last_o     = is_write ? last_r : (cnt_r == last_beat);
  // reads run from the header alone, writes wait for each data word
  assign fsm_v_o        = (state_r == e_busy) & (~is_write | data_v_r);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_r    <= e_idle;
      ready_en_r <= 1'b0;
      data_v_r   <= 1'b0;
      cnt_r      <= '0;
    end else begin
      ready_en_r <= 1'b1;
      unique case (state_r)
        e_idle: begin
          if (accept) begin
            state_r  <= e_busy;
            cnt_r    <= '0;
            data_v_r <= 1'b1;
          end
        end
        default: begin
          if (fsm_yumi_i) begin
            cnt_r    <= cnt_r + 1'b1;
            data_v_r <= 1'b0;
            if (fsm_last_o) begin
              state_r <= e_idle;
            end
          end
          // next write word never arrives together with yumi
          if (accept) begin
            data_v_r <= 1'b1;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      data_r <= mem_fwd_data_i;
      last_r <= mem_fwd_last_i;
    end
    if (accept && (state_r == e_idle)) begin
      type_r <= mem_fwd_msg_type_i;
      addr_r <= mem_fwd_addr_i;
      size_r <= mem_fwd_size_i;
    end
  end

  // the bus side only consumes a beat that is offered
  a_yumi_needs_v: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    fsm_yumi_i |-> fsm_v_o)
    else $error("fwd pump yumi without a valid beat");

endmodule

`default_nettype wire

//--- rtl/rev_stream_pump.sv
// response pump: beat counter, last flag and write beat suppression
`default_nettype none

`include "bridge_settings.svh"

module rev_stream_pump
  import mem_msg_pkg::*;
(
  input  wire             clk_i,
  input  wire             rst_n_i,

  input  wire msg_type_e  fsm_msg_type_i,
  input  wire paddr_t     fsm_addr_i,
  input  wire msg_size_e  fsm_size_i,
  input  wire data_t      fsm_data_i,
  input  wire             fsm_v_i,
  output logic            fsm_ready_and_o,

  output msg_type_e       msg_msg_type_o,
  output paddr_t          msg_addr_o,
  output msg_size_e       msg_size_o,
  output data_t           msg_data_o,
  output logic            msg_last_o,
  output logic            msg_v_o,
  input  wire             msg_ready_and_i
);

  beat_cnt_t cnt_r;
  beat_cnt_t last_beat;
  logic      is_write;
  logic      beat_last;
  logic      accept;

  assign is_write  = (fsm_msg_type_i == e_mem_uc_wr);
  assign last_beat = size_last_beat(fsm_size_i);
  assign beat_last = (cnt_r == last_beat);

  // a write answers once, on its final beat
  assign msg_v_o = fsm_v_i & (~is_write | beat_last);

  // dropped write beats need no room downstream
  assign fsm_ready_and_o = msg_ready_and_i | (is_write & ~beat_last);
  assign accept          = fsm_v_i & fsm_ready_and_o;

  assign msg_msg_type_o = fsm_msg_type_i;
  assign msg_addr_o     = fsm_addr_i;
  assign msg_size_o     = fsm_size_i;
  assign msg_last_o     = beat_last;
  assign msg_data_o     = is_write ? '0 : fsm_data_i;

  // counts in step with the command pump, both advance on the same ack
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cnt_r <= '0;
    end else if (accept) begin
      if (beat_last) begin
        cnt_r <= '0;
      end else begin
        cnt_r <= cnt_r + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/rev_fifo.sv
// return FIFO: circular buffer with read and write pointers and a count
`default_nettype none

`include "bridge_settings.svh"

module rev_fifo
  import mem_msg_pkg::*;
(
  input  wire             clk_i,
  input  wire             rst_n_i,

  input  wire rev_entry_t data_i,
  input  wire             v_i,
  output logic            ready_o,

  output rev_entry_t      data_o,
  output logic            v_o,
  input  wire             yumi_i
);

  rev_entry_t                            mem_r [`BRIDGE_REV_FIFO_ELS];
  logic [`BRIDGE_REV_FIFO_PTR_WIDTH-1:0] wr_ptr_r;
  logic [`BRIDGE_REV_FIFO_PTR_WIDTH-1:0] rd_ptr_r;
  logic [`BRIDGE_REV_FIFO_PTR_WIDTH:0]   count_r;
  logic                                  push;
  logic                                  pop;

  // both flags come from the count register only
  assign ready_o = (count_r != `BRIDGE_REV_FIFO_ELS);
  assign v_o     = (count_r != '0);
  assign data_o  = mem_r[rd_ptr_r];

  assign push = v_i & ready_o;
  assign pop  = yumi_i & v_o;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end else begin
      if (push) begin
        wr_ptr_r <= wr_ptr_r + 1'b1;
      end
      if (pop) begin
        rd_ptr_r <= rd_ptr_r + 1'b1;
      end
      unique case ({push, pop})
        2'b10:   count_r <= count_r + 1'b1;
        2'b01:   count_r <= count_r - 1'b1;
        default: count_r <= count_r;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_r[wr_ptr_r] <= data_i;
    end
  end

  // the bridge holds stb low while full, so no response shows up then
  a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (count_r == `BRIDGE_REV_FIFO_ELS) |-> !v_i)
    else $error("response offered to a full return FIFO");

  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    yumi_i |-> v_o)
    else $error("return FIFO popped while empty");

endmodule

`default_nettype wire

//--- rtl/bus_pack.sv
// read data packer: replicates 1, 2 or 4 addressed bytes over the bus word
`default_nettype none

`include "bridge_settings.svh"

module bus_pack
  import mem_msg_pkg::*;
(
  input  wire data_t                         data_i,
  input  wire [`BRIDGE_BUS_OFFSET_WIDTH-1:0] offset_i,
  input  wire msg_size_e                     size_i,
  output data_t                              data_o
);

  // narrow sizes are aligned, so the low offset bits drop out
  always_comb begin
    unique case (size_i)
      e_size_1: begin
        data_o = {8{data_i[{offset_i, 3'b000} +: 8]}};
      end
      e_size_2: begin
        data_o = {4{data_i[{offset_i[2:1], 4'b0000} +: 16]}};
      end
      e_size_4: begin
        data_o = {2{data_i[{offset_i[2], 5'b00000} +: 32]}};
      end
      default: begin
        data_o = data_i;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- rtl/wb_master_bridge.sv
// top: Wishbone B4 master control, pumps, return FIFO and read data packer
`default_nettype none

`include "bridge_settings.svh"

module wb_master_bridge
  import mem_msg_pkg::*;
  import wb_pkg::*;
(
  input  wire             clk_i,
  input  wire             rst_n_i,

  input  wire msg_type_e  mem_fwd_msg_type_i,
  input  wire paddr_t     mem_fwd_addr_i,
  input  wire msg_size_e  mem_fwd_size_i,
  input  wire data_t      mem_fwd_data_i,
  input  wire             mem_fwd_last_i,
  input  wire             mem_fwd_v_i,
  output logic            mem_fwd_ready_and_o,

  output msg_type_e       mem_rev_msg_type_o,
  output paddr_t          mem_rev_addr_o,
  output msg_size_e       mem_rev_size_o,
  output data_t           mem_rev_data_o,
  output logic            mem_rev_last_o,
  output logic            mem_rev_v_o,
  input  wire             mem_rev_ready_and_i,

  output wb_adr_t         adr_o,
  output data_t           dat_o,
  output logic            cyc_o,
  output logic            stb_o,
  output wb_sel_t         sel_o,
  output logic            we_o,
  output wb_cti_e         cti_o,
  output wb_bte_e         bte_o,
  input  wire data_t      dat_i,
  input  wire             ack_i
);

  msg_type_e pump_type;
  paddr_t    pump_addr;
  msg_size_e pump_size;
  data_t     pump_data;
  logic      pump_last;
  logic      pump_v;
  logic      pump_yumi;

  logic      rev_v;
  logic      rev_ready;
  data_t     rev_data;

  msg_type_e rev_msg_type;
  paddr_t    rev_msg_addr;
  msg_size_e rev_msg_size;
  data_t     rev_msg_data;
  logic      rev_msg_last;
  logic      rev_msg_v;
  logic      rev_msg_ready;

  rev_entry_t rev_entry_li;
  rev_entry_t rev_entry_lo;
  logic       rev_type_bit;
  logic [2:0] rev_size_bits;

  logic [`BRIDGE_BUS_OFFSET_WIDTH-1:0] byte_offset;
  logic [`BRIDGE_BUS_OFFSET_WIDTH-1:0] align_mask;
  beat_cnt_t                           last_beat;

  fwd_stream_pump pump_in (
    .clk_i               (clk_i),
    .rst_n_i             (rst_n_i),
    .mem_fwd_msg_type_i  (mem_fwd_msg_type_i),
    .mem_fwd_addr_i      (mem_fwd_addr_i),
    .mem_fwd_size_i      (mem_fwd_size_i),
    .mem_fwd_data_i      (mem_fwd_data_i),
    .mem_fwd_last_i      (mem_fwd_last_i),
    .mem_fwd_v_i         (mem_fwd_v_i),
    .mem_fwd_ready_and_o (mem_fwd_ready_and_o),
    .fsm_msg_type_o      (pump_type),
    .fsm_addr_o          (pump_addr),
    .fsm_size_o          (pump_size),
    .fsm_data_o          (pump_data),
    .fsm_last_o          (pump_last),
    .fsm_v_o             (pump_v),
    .fsm_yumi_i          (pump_yumi)
  );

  rev_stream_pump pump_out (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .fsm_msg_type_i  (pump_type),
    .fsm_addr_i      (pump_addr),
    .fsm_size_i      (pump_size),
    .fsm_data_i      (rev_data),
    .fsm_v_i         (rev_v),
    .fsm_ready_and_o (rev_ready),
    .msg_msg_type_o  (rev_msg_type),
    .msg_addr_o      (rev_msg_addr),
    .msg_size_o      (rev_msg_size),
    .msg_data_o      (rev_msg_data),
    .msg_last_o      (rev_msg_last),
    .msg_v_o         (rev_msg_v),
    .msg_ready_and_i (rev_msg_ready)
  );

  assign rev_entry_li = {rev_msg_type, rev_msg_addr, rev_msg_size, rev_msg_data, rev_msg_last};

  rev_fifo return_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .data_i  (rev_entry_li),
    .v_i     (rev_msg_v),
    .ready_o (rev_msg_ready),
    .data_o  (rev_entry_lo),
    .v_o     (mem_rev_v_o),
    .yumi_i  (mem_rev_ready_and_i & mem_rev_v_o)
  );

  assign {rev_type_bit, mem_rev_addr_o, rev_size_bits, mem_rev_data_o, mem_rev_last_o} =
    rev_entry_lo;
  assign mem_rev_msg_type_o = msg_type_e'(rev_type_bit);
  assign mem_rev_size_o     = msg_size_e'(rev_size_bits);

  assign byte_offset = pump_addr[`BRIDGE_BUS_OFFSET_WIDTH-1:0];

  bus_pack read_pack (
    .data_i   (dat_i),
    .offset_i (byte_offset),
    .size_i   (pump_size),
    .data_o   (rev_data)
  );

  // strobe only when the response has somewhere to go
  assign cyc_o     = pump_v;
  assign stb_o     = pump_v & rev_ready;
  assign pump_yumi = ack_i & cyc_o & stb_o;
  // response path sees the ack only while a beat is pending
  assign rev_v     = pump_v & ack_i;

  assign adr_o     = pump_addr[`BRIDGE_PADDR_WIDTH-1:`BRIDGE_BUS_OFFSET_WIDTH];
  assign dat_o     = pump_data;
  assign we_o      = (pump_type == e_mem_uc_wr);
  assign last_beat = size_last_beat(pump_size);

  always_comb begin
    unique case (pump_size)
      e_size_1: sel_o = wb_sel_t'(8'h01) << byte_offset;
      e_size_2: sel_o = wb_sel_t'(8'h03) << byte_offset;
      e_size_4: sel_o = wb_sel_t'(8'h0F) << byte_offset;
      default:  sel_o = wb_sel_t'(8'hFF);
    endcase

    // only wrapped bursts, everything else runs as classic cycles
    unique case (last_beat)
      beat_cnt_t'(3):  bte_o = e_bte_wrap4;
      beat_cnt_t'(7):  bte_o = e_bte_wrap8;
      beat_cnt_t'(15): bte_o = e_bte_wrap16;
      default:         bte_o = e_bte_linear;
    endcase

    if (bte_o == e_bte_linear) begin
      cti_o = e_cti_classic;
    end else if (pump_last) begin
      cti_o = e_cti_eob;
    end else begin
      cti_o = e_cti_incr;
    end
  end

  // alignment follows the size, capped at one bus word
  assign align_mask = (mem_fwd_size_i >= e_size_8) ? 3'b111
                    : 3'((4'b0001 << mem_fwd_size_i) - 4'b0001);

  a_cmd_aligned: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (mem_fwd_v_i && mem_fwd_ready_and_o) |-> ((mem_fwd_addr_i[2:0] & align_mask) == '0))
    else $error("command address not aligned to its size");

  a_cmd_uncached: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_fwd_v_i |-> (!$isunknown(mem_fwd_msg_type_i)
      && (mem_fwd_msg_type_i inside {e_mem_uc_rd, e_mem_uc_wr})))
    else $error("command type must be an uncached read or write");

endmodule

`default_nettype wire

//--- test/tb_clock_gen.sv
// testbench clock and reset source: 8 ns clock, reset low for 5 cycles
`default_nettype none

module tb_clock_gen (
  output logic clk_o,
  output logic rst_n_o
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk_o = 1'b0;
    forever begin
      #4 clk_o = ~clk_o;
    end
  end

  // release on a falling edge, like every other testbench input
  initial begin
    rst_n_o = 1'b0;
    repeat (5) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

//--- test/tb_wb_memory.sv
// Wishbone slave memory model: 4 KiB bytes, random wait states, burst checks
`default_nettype none

module tb_wb_memory
  import mem_msg_pkg::*;
  import wb_pkg::*;
(
  input  wire          clk_i,
  input  wire          rst_n_i,
  input  wire wb_adr_t adr_i,
  input  wire data_t   dat_i,
  input  wire wb_sel_t sel_i,
  input  wire          we_i,
  input  wire          cyc_i,
  input  wire          stb_i,
  input  wire wb_cti_e cti_i,
  input  wire wb_bte_e bte_i,
  output data_t        dat_o,
  output logic         ack_o,
  output logic         burst_err_o
);
  timeunit 1ns;
  timeprecision 1ps;

  logic [7:0] mem [4096];
  int         seed;
  int         rnd;
  int         wait_left;
  int         beat_idx;
  int         nbeats;
  wb_adr_t    first_adr;
  wb_adr_t    exp_adr;
  wb_cti_e    exp_cti;

  initial begin
    seed = 48;
    for (int i = 0; i < 4096; i++) begin
      mem[i] = 8'(i) ^ (8'(i >> 8) * 8'h1D);
    end
  end

  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      ack_o       <= 1'b0;
      wait_left   <= 0;
      beat_idx    <= 0;
      burst_err_o <= 1'b0;
    end else if (ack_o) begin
      ack_o <= 1'b0;
    end else if (cyc_i && stb_i) begin
      if (wait_left > 0) begin
        wait_left <= wait_left - 1;
      end else begin
        ack_o <= 1'b1;
        for (int b = 0; b < 8; b++) begin
          dat_o[b*8 +: 8] <= mem[{adr_i[8:0], 3'(b)}];
          if (we_i && sel_i[b]) begin
            mem[{adr_i[8:0], 3'(b)}] <= dat_i[b*8 +: 8];
          end
        end
        rnd = $random(seed);
        wait_left <= (rnd & 32'h7fff_ffff) % 3;
        if (bte_i != e_bte_linear) begin
          nbeats  = 4 << (int'(bte_i) - 1);
          exp_cti = (beat_idx == nbeats - 1) ? e_cti_eob : e_cti_incr;
          if (beat_idx == 0) begin
            first_adr = adr_i;
          end
          // wrapped order around the first beat
          exp_adr = wb_adr_t'((first_adr / nbeats) * nbeats
                              + (first_adr % nbeats + beat_idx) % nbeats);
          if (cti_i != exp_cti || adr_i != exp_adr) begin
            $display("burst beat %0d has cti %0d adr %h, wanted cti %0d adr %h",
                     beat_idx, cti_i, adr_i, exp_cti, exp_adr);
            burst_err_o <= 1'b1;
          end
          beat_idx <= (beat_idx == nbeats - 1) ? 0 : beat_idx + 1;
        end else if (cti_i != e_cti_classic) begin
          $display("single cycle with a non-classic cti %0d", cti_i);
          burst_err_o <= 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- test/tb_wb_master_bridge.sv
// testbench top: stimulus table, shadow memory, response and bus checks
`default_nettype none

`include "bridge_settings.svh"

module tb_wb_master_bridge
  import mem_msg_pkg::*;
  import wb_pkg::*;
;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_ROWS = 16;
  localparam int TIMEOUT  = 200;

  typedef struct {
    string     name;
    msg_type_e mtype;
    paddr_t    addr;
    msg_size_e size;
    data_t     wdata;
    logic      bp;
  } row_t;

  logic clk;
  logic rst_n;

  msg_type_e mem_fwd_msg_type_i;
  paddr_t    mem_fwd_addr_i;
  msg_size_e mem_fwd_size_i;
  data_t     mem_fwd_data_i;
  logic      mem_fwd_last_i;
  logic      mem_fwd_v_i;
  logic      mem_fwd_ready_and_o;
  msg_type_e mem_rev_msg_type_o;
  paddr_t    mem_rev_addr_o;
  msg_size_e mem_rev_size_o;
  data_t     mem_rev_data_o;
  logic      mem_rev_last_o;
  logic      mem_rev_v_o;
  logic      mem_rev_ready_and_i;
  wb_adr_t   adr_o;
  data_t     dat_o;
  logic      cyc_o;
  logic      stb_o;
  wb_sel_t   sel_o;
  logic      we_o;
  wb_cti_e   cti_o;
  wb_bte_e   bte_o;
  data_t     dat_i;
  logic      ack_i;
  logic      mem_burst_err;

  row_t       rows [NUM_ROWS];
  logic [7:0] shadow [4096];
  int         seed;
  int         ack_total;
  wb_sel_t    last_sel;
  wb_cti_e    last_cti;
  wb_bte_e    last_bte;

  tb_clock_gen clock_gen (.clk_o(clk), .rst_n_o(rst_n));

  wb_master_bridge UUT (
    .clk_i(clk), .rst_n_i(rst_n),
    .mem_fwd_msg_type_i(mem_fwd_msg_type_i), .mem_fwd_addr_i(mem_fwd_addr_i),
    .mem_fwd_size_i(mem_fwd_size_i), .mem_fwd_data_i(mem_fwd_data_i),
    .mem_fwd_last_i(mem_fwd_last_i), .mem_fwd_v_i(mem_fwd_v_i),
    .mem_fwd_ready_and_o(mem_fwd_ready_and_o),
    .mem_rev_msg_type_o(mem_rev_msg_type_o), .mem_rev_addr_o(mem_rev_addr_o),
    .mem_rev_size_o(mem_rev_size_o), .mem_rev_data_o(mem_rev_data_o),
    .mem_rev_last_o(mem_rev_last_o), .mem_rev_v_o(mem_rev_v_o),
    .mem_rev_ready_and_i(mem_rev_ready_and_i),
    .adr_o(adr_o), .dat_o(dat_o), .cyc_o(cyc_o), .stb_o(stb_o), .sel_o(sel_o),
    .we_o(we_o), .cti_o(cti_o), .bte_o(bte_o), .dat_i(dat_i), .ack_i(ack_i)
  );

  tb_wb_memory wb_memory (
    .clk_i(clk), .rst_n_i(rst_n), .adr_i(adr_o), .dat_i(dat_o), .sel_i(sel_o),
    .we_i(we_o), .cyc_i(cyc_o), .stb_i(stb_o), .cti_i(cti_o), .bte_i(bte_o),
    .dat_o(dat_i), .ack_o(ack_i), .burst_err_o(mem_burst_err)
  );

  // ack is registered in the slave, so it is stable here
  always @(negedge clk) begin
    if (cyc_o && stb_o && ack_i) begin
      ack_total <= ack_total + 1;
      last_sel  <= sel_o;
      last_cti  <= cti_o;
      last_bte  <= bte_o;
    end
  end

  task automatic stop_with_failure();
    $display("TESTBENCH FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic report_mismatch(input string name, input logic [63:0] exp_v,
                                 input logic [63:0] act_v);
    $display("ERR %s expected %h actual %h", name, exp_v, act_v);
    stop_with_failure();
  endtask

  task automatic report_problem(input string what);
    $display("%s", what);
    stop_with_failure();
  endtask

  function automatic int beats_of(input msg_size_e size);
    return (size >= e_size_16) ? (1 << (int'(size) - 3)) : 1;
  endfunction

  // bytes that a beat touches, capped at one bus word
  function automatic int width_of(input msg_size_e size);
    return (size >= e_size_8) ? 8 : (1 << int'(size));
  endfunction

  function automatic wb_sel_t sel_of(input int r);
    return wb_sel_t'((16'h1 << width_of(rows[r].size)) - 1) << rows[r].addr[2:0];
  endfunction

  // word address of beat i, wrapping inside the burst
  function automatic logic [28:0] word_of(input int r, input int i);
    logic [28:0] w0;
    int          nb;
    w0 = rows[r].addr[31:3];
    nb = beats_of(rows[r].size);
    return 29'((w0 / nb) * nb + (w0 % nb + i) % nb);
  endfunction

  function automatic data_t beat_data(input int r, input int i);
    return rows[r].wdata + data_t'(i) * 64'h1111_1111_1111_1111;
  endfunction

  function automatic data_t expected_read(input int r, input int i);
    data_t       e;
    int          nb;
    logic [28:0] w;
    logic [11:0] base;
    nb   = width_of(rows[r].size);
    w    = word_of(r, i);
    base = {w[8:0], 3'b000} + 12'(rows[r].addr[2:0] & 3'(~(nb - 1)));
    for (int b = 0; b < 8; b++) begin
      e[b*8 +: 8] = shadow[base + 12'(b % nb)];
    end
    return e;
  endfunction

  task automatic send_command(input int r);
    int          beats;
    int          wait_cnt;
    data_t       d;
    wb_sel_t     sel;
    logic [28:0] w;
    beats = (rows[r].mtype == e_mem_uc_wr) ? beats_of(rows[r].size) : 1;
    sel   = sel_of(r);
    for (int i = 0; i < beats; i++) begin
      @(negedge clk);
      d = beat_data(r, i);
      mem_fwd_msg_type_i = rows[r].mtype;
      mem_fwd_addr_i     = rows[r].addr;
      mem_fwd_size_i     = rows[r].size;
      mem_fwd_data_i     = d;
      mem_fwd_last_i     = (i == beats - 1);
      mem_fwd_v_i        = 1'b1;
      wait_cnt = 0;
      while (!mem_fwd_ready_and_o) begin
        @(negedge clk);
        wait_cnt++;
        if (wait_cnt > TIMEOUT) begin
          report_problem({rows[r].name, ": the bridge never accepted a command beat"});
        end
      end
      if (rows[r].mtype == e_mem_uc_wr) begin
        w = word_of(r, i);
        for (int b = 0; b < 8; b++) begin
          if (sel[b]) begin
            shadow[{w[8:0], 3'(b)}] = d[b*8 +: 8];
          end
        end
      end
    end
    @(negedge clk);
    mem_fwd_v_i = 1'b0;
  endtask

  task automatic collect_responses(input int r, input int base_acks);
    int   n;
    int   got;
    int   wait_cnt;
    int   rnd;
    logic rdy;
    logic is_rd;
    is_rd    = (rows[r].mtype == e_mem_uc_rd);
    n        = is_rd ? beats_of(rows[r].size) : 1;
    got      = 0;
    wait_cnt = 0;
    while (got < n) begin
      @(negedge clk);
      rnd = $random(seed);
      rdy = rows[r].bp ? rnd[0] : 1'b1;
      mem_rev_ready_and_i = rdy;
      if (mem_rev_v_o && rdy) begin
        assert (mem_rev_msg_type_o == rows[r].mtype)
          else report_mismatch({rows[r].name, " type"}, 64'(rows[r].mtype),
                               64'(mem_rev_msg_type_o));
        assert (mem_rev_size_o == rows[r].size)
          else report_mismatch({rows[r].name, " size"}, 64'(rows[r].size),
                               64'(mem_rev_size_o));
        assert (mem_rev_last_o == (got == n - 1))
          else report_mismatch({rows[r].name, " last"}, 64'(got == n - 1), 64'(mem_rev_last_o));
        if (is_rd) begin
          assert (mem_rev_addr_o == {word_of(r, got), rows[r].addr[2:0]})
            else report_mismatch({rows[r].name, " addr"}, 64'({word_of(r, got),
                                 rows[r].addr[2:0]}), 64'(mem_rev_addr_o));
          assert (mem_rev_data_o == expected_read(r, got))
            else report_mismatch({rows[r].name, " data"}, expected_read(r, got), mem_rev_data_o);
        end else begin
          assert (mem_rev_data_o == '0)
            else report_mismatch({rows[r].name, " data"}, 64'h0, mem_rev_data_o);
        end
        got++;
        wait_cnt = 0;
      end else begin
        wait_cnt++;
        if (wait_cnt > TIMEOUT) begin
          report_problem({rows[r].name, ": a response never arrived"});
        end
      end
      // acked read beats not yet taken all sit in the return FIFO
      if (is_rd) begin
        assert (ack_total - base_acks - got <= `BRIDGE_REV_FIFO_ELS)
          else report_problem({rows[r].name, ": more acks than the return FIFO can hold"});
      end
    end
    @(negedge clk);
    mem_rev_ready_and_i = 1'b0;
  endtask

  initial begin
    int wait_cnt;
    int base_acks;
    int n;
    seed      = 48;
    ack_total = 0;
    mem_fwd_msg_type_i  = e_mem_uc_rd;
    mem_fwd_addr_i      = '0;
    mem_fwd_size_i      = e_size_8;
    mem_fwd_data_i      = '0;
    mem_fwd_last_i      = 1'b0;
    mem_fwd_v_i         = 1'b0;
    mem_rev_ready_and_i = 1'b0;
    for (int i = 0; i < 4096; i++) begin
      shadow[i] = 8'(i) ^ (8'(i >> 8) * 8'h1D);
    end

    rows[0]  = '{"wr8",      e_mem_uc_wr, 32'h100, e_size_8,   64'h0123_4567_89ab_cdef, 1'b0};
    rows[1]  = '{"rd8",      e_mem_uc_rd, 32'h100, e_size_8,   64'h0,                   1'b0};
    rows[2]  = '{"wr1",      e_mem_uc_wr, 32'h205, e_size_1,   64'h5a5a_5a5a_5a5a_5a5a, 1'b0};
    rows[3]  = '{"rd1",      e_mem_uc_rd, 32'h205, e_size_1,   64'h0,                   1'b0};
    rows[4]  = '{"wr2",      e_mem_uc_wr, 32'h20a, e_size_2,   64'hc3c3_7e7e_1234_beef, 1'b0};
    rows[5]  = '{"rd2",      e_mem_uc_rd, 32'h20a, e_size_2,   64'h0,                   1'b0};
    rows[6]  = '{"wr4",      e_mem_uc_wr, 32'h304, e_size_4,   64'hdead_beef_cafe_f00d, 1'b0};
    rows[7]  = '{"rd4",      e_mem_uc_rd, 32'h304, e_size_4,   64'h0,                   1'b0};
    rows[8]  = '{"rd8_keep", e_mem_uc_rd, 32'h200, e_size_8,   64'h0,                   1'b0};
    rows[9]  = '{"wr32",     e_mem_uc_wr, 32'h410, e_size_32,  64'h1000_2000_3000_4000, 1'b0};
    rows[10] = '{"rd32",     e_mem_uc_rd, 32'h410, e_size_32,  64'h0,                   1'b0};
    rows[11] = '{"wr64",     e_mem_uc_wr, 32'h528, e_size_64,  64'h0f0e_0d0c_0b0a_0908, 1'b0};
    rows[12] = '{"rd64",     e_mem_uc_rd, 32'h528, e_size_64,  64'h0,                   1'b0};
    rows[13] = '{"wr128",    e_mem_uc_wr, 32'h640, e_size_128, 64'h8765_4321_0fed_cba9, 1'b0};
    rows[14] = '{"rd128",    e_mem_uc_rd, 32'h678, e_size_128, 64'h0,                   1'b0};
    rows[15] = '{"rd128_bp", e_mem_uc_rd, 32'h600, e_size_128, 64'h0,                   1'b1};

    // outputs stay quiet through reset and the cycle after it
    // reset moves on falling edges, so it is looked at on rising ones
    wait_cnt = 0;
    @(posedge clk);
    while (!rst_n) begin
      @(negedge clk);
      assert (!cyc_o && !stb_o && !mem_rev_v_o && !mem_fwd_ready_and_o)
        else report_problem("reset: an output was active during reset");
      wait_cnt++;
      if (wait_cnt > TIMEOUT) begin
        report_problem("reset: reset was never released");
      end
      @(posedge clk);
    end
    @(negedge clk);
    assert (!cyc_o && !stb_o && !mem_rev_v_o)
      else report_problem("reset: an output was active right after reset");

    for (int r = 0; r < NUM_ROWS; r++) begin
      base_acks = ack_total;
      send_command(r);
      collect_responses(r, base_acks);
      n = beats_of(rows[r].size);
      assert (ack_total - base_acks == n)
        else report_mismatch({rows[r].name, " acks"}, 64'(n), 64'(ack_total - base_acks));
      if (n == 1) begin
        assert (last_sel == sel_of(r))
          else report_mismatch({rows[r].name, " sel"}, 64'(sel_of(r)), 64'(last_sel));
        assert (last_cti == e_cti_classic)
          else report_mismatch({rows[r].name, " cti"}, 64'(e_cti_classic), 64'(last_cti));
      end else begin
        assert (last_bte == wb_bte_e'(int'(rows[r].size) - 4))
          else report_mismatch({rows[r].name, " bte"}, 64'(int'(rows[r].size) - 4),
                               64'(last_bte));
      end
      assert (!mem_burst_err)
        else report_problem({rows[r].name, ": the memory model saw a bad burst"});
    end

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- project.f
+incdir+include
rtl/mem_msg_pkg.sv
rtl/wb_pkg.sv
rtl/fwd_stream_pump.sv
rtl/rev_stream_pump.sv
rtl/rev_fifo.sv
rtl/bus_pack.sv
rtl/wb_master_bridge.sv
test/tb_clock_gen.sv
test/tb_wb_memory.sv
test/tb_wb_master_bridge.sv

//--- run_sim.sh
#!/bin/sh
# build with Verilator, run, then judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --top-module tb_wb_master_bridge -f project.f \
  || { echo "build failed"; exit 1; }

./obj_dir/Vtb_wb_master_bridge > sim.log 2>&1
cat sim.log

grep -q "TESTBENCH FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "TESTBENCH PASSED" sim.log || { echo "simulation did not finish"; exit 1; }
exit 0
